/* include/scramble_defs.svh */
`ifndef SCRAMBLE_DEFS_SVH
`define SCRAMBLE_DEFS_SVH

// ======================================================================
// Bus widths
// ======================================================================

// Byte address of the download port
`define SCR_DL_ADDR_W 25

// Word address into the background picture memory
`define SCR_PIC_ADDR_W 24

// ======================================================================
// Download indexes and configuration
// ======================================================================

`define SCR_IDX_GAME 8'd1
`define SCR_IDX_DIP 8'd254
`define SCR_IDX_BG 8'd2

`define SCR_NUM_DIPS 8

// Slow enable divider, reload value N gives a period of N+1 cycles
`define SCR_CE179_RELOAD 13

`endif

/* src/game_pkg.sv */
`include "scramble_defs.svh"

package game_pkg;

	// Game numbers as sent over download index 1
	typedef enum logic [7:0] {
		scramble = 8'd0,
		amidar   = 8'd1,
		frogger  = 8'd2,
		scobra   = 8'd3,
		tazman   = 8'd4,
		armorcar = 8'd5,
		moonwar  = 8'd6,
		spdcoin  = 8'd7,
		calipso  = 8'd8,
		darkplnt = 8'd9,
		anteater = 8'd10,
		losttomb = 8'd11,
		theend   = 8'd12,
		mars     = 8'd13,
		stratgyx = 8'd14,
		turtles  = 8'd15,
		minefld  = 8'd16,
		rescue   = 8'd17,
		mimonkey = 8'd18
	} game_e;

	// Merged player controls, active high
	typedef struct packed {
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       fire_a;
		logic       fire_b;
		logic       fire_c;
		logic       fire_d;
		logic       fire_e;
		logic       start1;
		logic       start2;
		logic       coin;
		logic [3:0] pad;
	} controls_t;

	// Active-low input port bytes of the game board
	typedef struct packed {
		logic [7:0] pa;
		logic [7:0] pb;
		logic [7:0] pc;
		logic [7:0] pd;
	} ports_t;

	typedef struct packed {
		logic [7:0] hwsel;
		logic       landscape;
		logic       galaxian_video;
		logic       four_fire;
		logic [4:0] pad;
	} profile_t;

	// One write on the download port
	typedef struct packed {
		logic                      wr;
		logic [7:0]                index;
		logic [`SCR_DL_ADDR_W-1:0] addr;
		logic [7:0]                data;
	} dl_write_t;

	typedef logic [`SCR_NUM_DIPS-1:0][7:0] dip_bank_t;

endpackage

/* src/video_pkg.sv */
`include "scramble_defs.svh"

package video_pkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Background word, red sits in the low byte
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} bg_word_t;

	// Video timing from the game core
	typedef struct packed {
		logic hblank;
		logic vblank;
		logic vsync;
	} vid_timing_t;

	// ======================================================================
	// Wishbone classic read request
	// ======================================================================

	// Read-only, so no we and no write data
	typedef struct packed {
		logic                       cyc;
		logic                       stb;
		logic [`SCR_PIC_ADDR_W-1:0] adr;
	} wb_read_t;

endpackage

/* src/ce_gen.sv */
`timescale 1ns/1ps
`include "scramble_defs.svh"

module ce_gen
(
	input  logic clk_sys,
	input  logic rst,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_179
);

	logic [1:0] phase;
	logic [3:0] div179;

	// Fast enables from a free-running two-bit phase
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			phase <= 2'd0;
			ce_12 <= 1'b0;
			ce_6p <= 1'b0;
			ce_6n <= 1'b0;
		end
		else
		begin
			phase <= phase + 2'd1;
			ce_12 <= phase[0];
			// The two 6 MHz phases sit half a period apart
			ce_6p <= phase[0] & ~phase[1];
			ce_6n <= phase[0] & phase[1];
		end
	end

	// Slow enable, one pulse per reload period
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			div179 <= 4'(`SCR_CE179_RELOAD);
			ce_179 <= 1'b0;
		end
		else if (div179 == 4'd0)
		begin
			div179 <= 4'(`SCR_CE179_RELOAD);
			ce_179 <= 1'b1;
		end
		else
		begin
			div179 <= div179 - 4'd1;
			ce_179 <= 1'b0;
		end
	end

endmodule

/* src/game_config.sv */
`timescale 1ns/1ps
`include "scramble_defs.svh"

module game_config
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  game_pkg::dl_write_t   dl,
	output game_pkg::game_e       game,
	output game_pkg::dip_bank_t   dips,
	output logic                  bg_loaded
);

	localparam int DIP_SEL_W = $clog2(`SCR_NUM_DIPS);

	logic wr_game;
	logic wr_dip;
	logic wr_bg;

	// ======================================================================
	// Download decode
	// ======================================================================

	assign wr_game = dl.wr && (dl.index == `SCR_IDX_GAME);
	// Only the first few addresses of the DIP index carry switch bytes
	assign wr_dip  = dl.wr && (dl.index == `SCR_IDX_DIP) && (dl.addr < `SCR_NUM_DIPS);
	assign wr_bg   = dl.wr && (dl.index == `SCR_IDX_BG);

	// ======================================================================
	// Configuration registers
	// ======================================================================

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			game      <= game_pkg::scramble;
			dips      <= '1;
			bg_loaded <= 1'b0;
		end
		else
		begin
			if (wr_game)
				game <= game_pkg::game_e'(dl.data);
			if (wr_dip)
				dips[dl.addr[DIP_SEL_W-1:0]] <= dl.data;
			// Any background byte marks the picture as present
			if (wr_bg)
				bg_loaded <= 1'b1;
		end
	end

endmodule

/* src/input_mapper.sv */
`timescale 1ns/1ps

module input_mapper
(
	input  logic                 clk_sys,
	input  logic                 rst,
	input  game_pkg::game_e      game,
	input  logic                 fire_mode,
	input  game_pkg::dip_bank_t  dips,
	input  game_pkg::controls_t  controls,
	output game_pkg::ports_t     ports,
	output game_pkg::profile_t   profile
);

	game_pkg::ports_t   raw;
	game_pkg::profile_t prof_nxt;

	// ======================================================================
	// Per-game layout table
	// ======================================================================

	always_comb
	begin
		prof_nxt = '0;
		// Scramble layout unless the game overrides it
		raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
			controls.fire_a, 1'b0, controls.fire_b, controls.up};
		raw.pb = ~{controls.start1, controls.start2, controls.left, controls.right,
			controls.fire_a, controls.fire_b, 2'b00};
		raw.pc = ~{1'b0, controls.down, 1'b0, controls.up, 3'b000, controls.down};
		raw.pd = 8'hFF;

		case (game)
			game_pkg::frogger:
				prof_nxt.hwsel = 8'd1;
			game_pkg::scobra, game_pkg::armorcar:
				prof_nxt.hwsel = 8'd2;
			game_pkg::tazman:
			begin
				prof_nxt.hwsel = 8'd2;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.down, controls.up, controls.fire_a, controls.fire_b};
				raw.pb = 8'hFF;
				raw.pc = ~{1'b0, controls.start2, 5'b00000, controls.start1};
			end
			game_pkg::spdcoin:
			begin
				prof_nxt.hwsel = 8'd2;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.start2, 1'b0, controls.start1, 1'b0};
				raw.pb = 8'hFF;
				raw.pc = 8'hFF;
			end
			game_pkg::calipso:
			begin
				prof_nxt.hwsel = 8'd3;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.down, controls.up, 1'b0, controls.start2 | controls.fire_a};
				raw.pb = ~{2'b00, controls.left, controls.right, controls.down, controls.up, 2'b00};
				raw.pc = ~{7'b0000000, controls.fire_a | controls.start1};
			end
			game_pkg::anteater:
			begin
				prof_nxt.hwsel = 8'd6;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.down, controls.up, 1'b0, controls.fire_a};
				raw.pb = ~{1'b0, controls.fire_a, controls.left, controls.right,
					controls.up, controls.down, 2'b00};
				raw.pc = ~{1'b0, controls.start2, 5'b00000, controls.start1};
			end
			game_pkg::losttomb:
			begin
				prof_nxt.hwsel     = 8'd7;
				prof_nxt.four_fire = 1'b1;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.down, controls.up, controls.start1, controls.start2};
				// Move+fire mode puts the stick on the second port
				raw.pb = fire_mode ?
					~{1'b0, controls.fire_e | controls.fire_a, controls.left, controls.right,
						controls.down, controls.up, 2'b00} :
					~{1'b0, controls.fire_e, controls.fire_d, controls.fire_a,
						controls.fire_b, controls.fire_c, 2'b00};
				raw.pc = 8'hFF;
			end
			game_pkg::theend:
				prof_nxt.galaxian_video = 1'b1;
			game_pkg::mars:
			begin
				prof_nxt.hwsel     = 8'd10;
				prof_nxt.four_fire = 1'b1;
				if (fire_mode)
				begin
					raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
						controls.left, controls.right, 1'b0, controls.up};
					raw.pb = ~{controls.start1, controls.start2, controls.left, controls.right,
						controls.left, controls.right, 2'b00};
					raw.pc = ~{controls.up, controls.down, controls.down, controls.up,
						3'b000, controls.down};
					raw.pd = ~{controls.up, 1'b0, controls.down, 5'b00000};
				end
				else
				begin
					raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
						controls.fire_d, controls.fire_a, 1'b0, controls.up};
					raw.pb = ~{controls.start1, controls.start2, controls.left, controls.right,
						controls.fire_d, controls.fire_a, 2'b00};
					raw.pc = ~{controls.fire_c, controls.down, controls.fire_b, controls.up,
						3'b000, controls.down};
					raw.pd = ~{controls.fire_c, 1'b0, controls.fire_b, 5'b00000};
				end
			end
			game_pkg::stratgyx:
			begin
				prof_nxt.hwsel     = 8'd5;
				prof_nxt.landscape = 1'b1;
				raw.pc = ~{controls.fire_c, controls.down, controls.fire_c, controls.up,
					3'b000, controls.down};
			end
			game_pkg::turtles:
			begin
				prof_nxt.hwsel = 8'd11;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.fire_a, 2'b00, controls.up};
				raw.pb = ~{controls.start1, controls.start2, controls.left, controls.right,
					controls.fire_a, 3'b000};
			end
			game_pkg::minefld, game_pkg::rescue:
			begin
				// Same wiring, different board select
				prof_nxt.hwsel     = (game == game_pkg::minefld) ? 8'd8 : 8'd9;
				prof_nxt.four_fire = 1'b1;
				raw.pa = ~{controls.coin, 1'b0, controls.left, controls.right,
					controls.down, controls.up, 1'b0, controls.start1};
				raw.pb = fire_mode ?
					~{2'b00, controls.left, controls.right, controls.down, controls.up, 2'b00} :
					~{2'b00, controls.fire_d, controls.fire_a, controls.fire_b,
						controls.fire_c, 2'b00};
				raw.pc = ~{1'b0, controls.start2, 5'b00000, controls.start1};
			end
			game_pkg::mimonkey:
				prof_nxt.hwsel = 8'd12;
			default:
				prof_nxt.hwsel = 8'd0;
		endcase
	end

	// Output stage, each port byte masked by its DIP byte
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			ports   <= '1;
			profile <= '0;
		end
		else
		begin
			ports.pa <= raw.pa & dips[0];
			ports.pb <= raw.pb & dips[1];
			ports.pc <= raw.pc & dips[2];
			ports.pd <= raw.pd & dips[3];
			profile  <= prof_nxt;
		end
	end

endmodule

/* src/bg_fetch_ctrl.sv */
`timescale 1ns/1ps
`include "scramble_defs.svh"

module bg_fetch_ctrl
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   ce_pix,
	input  video_pkg::vid_timing_t timing,
	input  logic                   bg_loaded,
	output video_pkg::wb_read_t    wb,
	input  logic                   wb_ack,
	output logic                   latch,
	output logic                   clear
);

	typedef enum logic [1:0] {
		OFF,
		SYNC,
		RUN,
		BUSY
	} state_e;

	state_e                     state;
	logic [`SCR_PIC_ADDR_W-1:0] addr;
	logic                       old_vs;
	logic                       vs_rise;
	logic                       active;

	assign vs_rise = ~old_vs & timing.vsync;
	assign active  = ~(timing.hblank | timing.vblank);

	// ======================================================================
	// Fetch FSM
	// ======================================================================

	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			state  <= OFF;
			addr   <= '0;
			old_vs <= 1'b0;
		end
		else
		begin
			// Vsync is sampled at pixel rate
			if (ce_pix)
				old_vs <= timing.vsync;
			case (state)
				OFF:
					if (bg_loaded)
						state <= SYNC;
				SYNC, RUN:
					if (ce_pix)
					begin
						if (vs_rise)
						begin
							addr  <= '0;
							state <= BUSY;
						end
						else if (state == RUN && active)
						begin
							addr  <= addr + 1'b1;
							state <= BUSY;
						end
					end
				// Pixel enables in here are dropped
				BUSY:
					if (wb_ack)
						state <= RUN;
				default:
					state <= OFF;
			endcase
		end
	end

	assign wb    = '{cyc: (state == BUSY), stb: (state == BUSY), adr: addr};
	assign latch = (state == BUSY) & wb_ack;
	assign clear = (state == OFF);

endmodule

/* src/bg_mixer.sv */
`timescale 1ns/1ps

module bg_mixer
(
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                latch,
	input  logic                clear,
	input  video_pkg::bg_word_t wb_dat,
	input  video_pkg::rgb_t     fg,
	output video_pkg::rgb_t     pix_out
);

	video_pkg::bg_word_t bg;
	logic                fg_on;

	// Background word, taken on the ack edge
	always_ff @(posedge clk_sys)
	begin
		if (rst)
			bg <= '0;
		else if (clear)
			bg <= '0;
		else if (latch)
			bg <= wb_dat;
	end

	// ======================================================================
	// Overlay
	// ======================================================================

	assign fg_on = (fg != '0);

	// Nonzero alpha lets the picture cover the game
	always_comb
	begin
		if (fg_on && (bg.a == 8'h00))
			pix_out = fg;
		else
			pix_out = '{r: bg.r, g: bg.g, b: bg.b};
	end

endmodule

/* src/scramble_ctrl_top.sv */
`timescale 1ns/1ps

module scramble_ctrl_top
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  game_pkg::dl_write_t    dl,
	input  game_pkg::controls_t    controls,
	input  logic                   fire_mode,
	input  video_pkg::vid_timing_t timing,
	input  video_pkg::rgb_t        fg,
	input  logic                   wb_ack,
	input  video_pkg::bg_word_t    wb_dat,
	output game_pkg::ports_t       ports,
	output game_pkg::profile_t     profile,
	output logic                   ce_12,
	output logic                   ce_6p,
	output logic                   ce_6n,
	output logic                   ce_179,
	output video_pkg::wb_read_t    wb,
	output video_pkg::rgb_t        pix_out
);

	game_pkg::game_e     game;
	game_pkg::dip_bank_t dips;
	logic                bg_loaded;
	logic                latch;
	logic                clear;

	// ======================================================================
	// Clocking and configuration
	// ======================================================================

	ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_179  (ce_179)
	);

	game_config u_game_config (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl        (dl),
		.game      (game),
		.dips      (dips),
		.bg_loaded (bg_loaded)
	);

	input_mapper u_input_mapper (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.game      (game),
		.fire_mode (fire_mode),
		.dips      (dips),
		.controls  (controls),
		.ports     (ports),
		.profile   (profile)
	);

	// ======================================================================
	// Background path
	// ======================================================================

	// The 6 MHz positive phase is the pixel rate
	bg_fetch_ctrl u_bg_fetch_ctrl (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce_pix    (ce_6p),
		.timing    (timing),
		.bg_loaded (bg_loaded),
		.wb        (wb),
		.wb_ack    (wb_ack),
		.latch     (latch),
		.clear     (clear)
	);

	bg_mixer u_bg_mixer (
		.clk_sys (clk_sys),
		.rst     (rst),
		.latch   (latch),
		.clear   (clear),
		.wb_dat  (wb_dat),
		.fg      (fg),
		.pix_out (pix_out)
	);

endmodule

/* dv/tb_scramble_ctrl.sv */
`timescale 1ns/1ps
`include "scramble_defs.svh"

module tb_scramble_ctrl;

	// One line of the mapping case file
	typedef struct packed {
		logic [7:0]      game;
		logic            fire_mode;
		logic [15:0]     controls;
		logic [3:0][7:0] dips;
		logic [31:0]     ports;
		logic [7:0]      hwsel;
	} map_case_t;

	logic                   clk_sys;
	logic                   rst;
	game_pkg::dl_write_t    dl;
	game_pkg::controls_t    controls;
	logic                   fire_mode;
	video_pkg::vid_timing_t timing;
	video_pkg::rgb_t        fg;
	logic                   wb_ack;
	video_pkg::bg_word_t    wb_dat;
	game_pkg::ports_t       ports;
	game_pkg::profile_t     profile;
	logic                   ce_12;
	logic                   ce_6p;
	logic                   ce_6n;
	logic                   ce_179;
	video_pkg::wb_read_t    wb;
	video_pkg::rgb_t        pix_out;

	map_case_t   cases[$];
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          limit_cycles;
	int          seed_init;
	bit          loaded;
	logic [31:0] mem_tag;
	int          ack_wait;
	logic        mon_on;
	logic        cyc_open;
	logic [23:0] held_adr;
	logic [23:0] next_adr;
	int          reads;

	scramble_ctrl_top u_dut (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl        (dl),
		.controls  (controls),
		.fire_mode (fire_mode),
		.timing    (timing),
		.fg        (fg),
		.wb_ack    (wb_ack),
		.wb_dat    (wb_dat),
		.ports     (ports),
		.profile   (profile),
		.ce_12     (ce_12),
		.ce_6p     (ce_6p),
		.ce_6n     (ce_6n),
		.ce_179    (ce_179),
		.wb        (wb),
		.pix_out   (pix_out)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("PASS  %s", name);
		else
		begin
			tests_failed++;
			$display("FAIL  %s (%0d errors)", name, errors - err0);
		end
	endtask

	// Picture memory content, the address plus the current tag
	function automatic logic [31:0] picture_word(input logic [23:0] adr);
		return 32'(adr) + mem_tag;
	endfunction

	// Game pixel wins only if lit and the picture is transparent there
	function automatic logic [23:0] expected_pixel(input logic [23:0] fg_val,
		input logic [31:0] word);
		if (fg_val != 24'h0 && word[31:24] == 8'h00)
			return fg_val;
		else
			return {word[7:0], word[15:8], word[23:16]};
	endfunction

	// Called on a falling edge, returns on the next one
	task automatic send_write(input logic [7:0] index, input int addr, input logic [7:0] data);
		dl = '{wr: 1'b1, index: index, addr: 25'(addr), data: data};
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	task automatic load_cases(output bit ok);
		int          fd;
		int          n;
		string       line;
		map_case_t   c;
		logic [31:0] f[9];
		ok = 1'b0;
		fd = $fopen("dv/input_cases.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#")
				begin
					n = $sscanf(line, "%d %d %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
					if (n == 9)
					begin
						c.game      = f[0][7:0];
						c.fire_mode = f[1][0];
						c.controls  = f[2][15:0];
						c.dips[0]   = f[3][7:0];
						c.dips[1]   = f[4][7:0];
						c.dips[2]   = f[5][7:0];
						c.dips[3]   = f[6][7:0];
						c.ports     = f[7];
						c.hwsel     = f[8][7:0];
						cases.push_back(c);
					end
				end
			end
			$fclose(fd);
			ok = (cases.size() > 0);
		end
	endtask

	// ======================================================================
	// Picture memory model and bus monitor
	// ======================================================================

	initial
	begin
		seed_init = $urandom(55619);
		forever
		begin
			@(negedge clk_sys);
			if (wb_ack)
			begin
				wb_ack <= 1'b0;
				ack_wait = -1;
			end
			else if (wb.cyc && wb.stb)
			begin
				if (ack_wait < 0)
					ack_wait = $urandom % 4;
				if (ack_wait == 0)
				begin
					wb_ack <= 1'b1;
					wb_dat <= picture_word(wb.adr);
				end
				else
					ack_wait = ack_wait - 1;
			end
		end
	end

	always @(negedge clk_sys)
	begin
		if (mon_on)
		begin
			// The word was latched on the edge that saw ack
			if (wb_ack)
			begin
				check_value(wb.cyc, 1'b0, "cycle still open after ack");
				check_value(pix_out, expected_pixel(fg, picture_word(held_adr)),
					"pix_out after fetch");
			end
			if (wb.cyc && wb.stb)
			begin
				if (!cyc_open)
				begin
					check_value(wb.adr, next_adr, "address of new read");
					held_adr = wb.adr;
					next_adr = wb.adr + 1'b1;
					reads    = reads + 1;
				end
				else
					check_value(wb.adr, held_adr, "adr changed in open cycle");
				cyc_open = 1'b1;
			end
			else
				cyc_open = 1'b0;
		end
	end

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic verify_reset();
		int err0;
		err0 = errors;
		check_value(ports, 32'hFFFF_FFFF, "ports after reset");
		check_value(profile.hwsel, 8'h00, "hwsel after reset");
		check_value(wb.cyc, 1'b0, "cyc after reset");
		check_value(pix_out, 24'h0, "pix_out after reset");
		report_test("reset state", err0);
	endtask

	task automatic count_enables();
		int n12;
		int n6p;
		int n6n;
		int n179;
		int err0;
		err0 = errors;
		n12  = 0;
		n6p  = 0;
		n6n  = 0;
		n179 = 0;
		// 280 is a multiple of both the 4 and 14 cycle periods
		repeat (280)
		begin
			@(negedge clk_sys);
			n12  += ce_12;
			n6p  += ce_6p;
			n6n  += ce_6n;
			n179 += ce_179;
			check_value(ce_6p & ce_6n, 1'b0, "ce_6p and ce_6n together");
		end
		check_value(n12, 140, "ce_12 pulse count");
		check_value(n6p, 70, "ce_6p pulse count");
		check_value(n6n, 70, "ce_6n pulse count");
		check_value(n179, 20, "ce_179 pulse count");
		report_test("clock enables", err0);
	endtask

	task automatic mix_without_picture();
		int err0;
		err0 = errors;
		fg = 24'h112233;
		@(negedge clk_sys);
		check_value(pix_out, 24'h112233, "pix_out lit game, no picture");
		fg = '0;
		@(negedge clk_sys);
		check_value(pix_out, 24'h0, "pix_out dark game, no picture");
		report_test("mix before picture load", err0);
	endtask

	task automatic map_all_cases();
		int err0;
		err0 = errors;
		foreach (cases[i])
		begin
			controls  = cases[i].controls;
			fire_mode = cases[i].fire_mode;
			send_write(`SCR_IDX_GAME, 0, cases[i].game);
			for (int d = 0; d < 4; d++)
				send_write(`SCR_IDX_DIP, d, cases[i].dips[d]);
			repeat (2) @(negedge clk_sys);
			check_value(ports, cases[i].ports, $sformatf("case %0d ports", i));
			check_value(profile.hwsel, cases[i].hwsel, $sformatf("case %0d hwsel", i));
		end
		report_test($sformatf("input mapping, %0d cases", cases.size()), err0);
	endtask

	task automatic ignored_writes();
		game_pkg::ports_t before_ports;
		logic [7:0]       before_hwsel;
		int               err0;
		err0         = errors;
		before_ports = ports;
		before_hwsel = profile.hwsel;
		send_write(`SCR_IDX_DIP, 8, 8'h00);
		// High address bit set, low bits point at a used DIP byte
		send_write(`SCR_IDX_DIP, 32'h0100_0001, 8'h00);
		send_write(8'd253, 0, 8'h00);
		send_write(8'd255, 2, 8'h00);
		repeat (3) @(negedge clk_sys);
		check_value(ports, before_ports, "ports after ignored writes");
		check_value(profile.hwsel, before_hwsel, "hwsel after ignored writes");
		report_test("ignored download writes", err0);
	endtask

	// Vsync pulse in vertical blank, then one active stretch
	task automatic fetch_line(input logic [31:0] tag, input logic [23:0] fg_val);
		mem_tag  = tag;
		fg       = fg_val;
		next_adr = '0;
		reads    = 0;
		cyc_open = 1'b0;
		mon_on   = 1'b1;
		timing   = '{hblank: 1'b1, vblank: 1'b1, vsync: 1'b1};
		repeat (8) @(negedge clk_sys);
		timing.vsync = 1'b0;
		repeat (8) @(negedge clk_sys);
		timing = '{hblank: 1'b0, vblank: 1'b0, vsync: 1'b0};
		repeat (48) @(negedge clk_sys);
		timing.hblank = 1'b1;
		while (wb.cyc)
			@(negedge clk_sys);
		repeat (2) @(negedge clk_sys);
		mon_on = 1'b0;
		check_value(reads > 1, 1'b1, "reads issued over the line");
	endtask

	task automatic fetch_and_mix();
		int err0;
		err0 = errors;
		send_write(`SCR_IDX_BG, 0, 8'h00);
		repeat (4) @(negedge clk_sys);
		fetch_line(32'h0030_2010, 24'h0);
		fg = 24'h405060;
		@(negedge clk_sys);
		check_value(pix_out, 24'h405060, "lit game over transparent picture");
		// Opaque picture this time
		fetch_line(32'h8030_2010, 24'h405060);
		report_test("background fetch and mix", err0);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial
	begin
		rst          = 1'b1;
		dl           = '0;
		controls     = '0;
		fire_mode    = 1'b0;
		timing       = '{hblank: 1'b1, vblank: 1'b1, vsync: 1'b0};
		fg           = '0;
		wb_ack       = 1'b0;
		wb_dat       = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		limit_cycles = 0;
		mem_tag      = '0;
		ack_wait     = -1;
		mon_on       = 1'b0;
		cyc_open     = 1'b0;
		held_adr     = '0;
		next_adr     = '0;
		reads        = 0;
		load_cases(loaded);
		if (!loaded)
		begin
			$display("Could not read any mapping cases from dv/input_cases.txt");
			$display("Something failed");
			$finish;
		end
		else
		begin
			limit_cycles = cases.size() * 20 + 2000;
			repeat (3) @(posedge clk_sys);
			@(negedge clk_sys);
			rst = 1'b0;
			verify_reset();
			count_enables();
			mix_without_picture();
			map_all_cases();
			ignored_writes();
			fetch_and_mix();
			$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
			if (errors == 0 && tests_failed == 0)
				$display("Everything OK");
			else
				$display("Something failed");
			$finish;
		end
	end

	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Timeout, the run did not finish within %0d cycles", limit_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
src/game_pkg.sv
src/video_pkg.sv
src/ce_gen.sv
src/game_config.sv
src/input_mapper.sv
src/bg_fetch_ctrl.sv
src/bg_mixer.sv
src/scramble_ctrl_top.sv
dv/tb_scramble_ctrl.sv

/* Bender.yml */
package:
  name: scramble_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/game_pkg.sv
      - src/video_pkg.sv
      - src/ce_gen.sv
      - src/game_config.sv
      - src/input_mapper.sv
      - src/bg_fetch_ctrl.sv
      - src/bg_mixer.sv
      - src/scramble_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_scramble_ctrl.sv

/* dv/input_cases.txt */
# game fire_mode controls dip0 dip1 dip2 dip3 ports hwsel
# game and fire_mode in decimal, the rest in hex, ports is pa pb pc pd
0 0 0000 FF FF FF FF FFFFFFFF 00
0 0 8810 FF FF FF FF 76F7EFFF 00
2 0 6000 FF FF FF FF DFDFBEFF 01
4 0 1440 7F FF FF FF 6EFFFEFF 02
7 0 0070 FF FF FF FF 75FFFFFF 02
8 0 8800 FF F0 FF 0F FAF0FE0F 03
10 0 4800 FF FF FF FF F6BBFFFF 06
11 0 02C0 FF FF FF FF FDBBFFFF 07
11 1 02C0 FF FF FF FF FDBFFFFF 07
12 0 2400 FF FF FF FF DDDBFFFF 00
13 0 8700 FF FF FF FF F6F74F5F 0A
13 1 9000 FF FF FF FF EAEB6F7F 0A
14 0 4200 FF FF FF FF FFFF1EFF 05
15 0 8820 FF FF FF FF F6B7EFFF 0B
16 0 0540 FF FF FF FF FED7FEFF 08
17 1 A000 FF FF FF FF DBDBFFFF 09
18 0 0010 FF FF FF 00 7FFFFF00 0C
6 0 0400 FF FF FF FF FDFBFFFF 00
3 0 0060 FF FF FF FF FF3FFFFF 02
